/* verilog.f */
fpsu_dims_pkg.sv
fpsu_op_pkg.sv
fpsu_issue_if.sv
operand_forward.sv
issue_stage.sv
simd_exec.sv
fpsu_top.sv
tb_fpsu.sv

/* Makefile */
SIM        = verilator
TOP        = tb_fpsu
FILELIST   = verilog.f
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_fpsu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fpsu import fpsu_dims_pkg::*, fpsu_op_pkg::*; ();

  typedef struct packed {
    logic             en;
    logic             ok;
    logic [RET_W-1:0] ret;
    data_t            data;
  } expect_t;

  logic             clk;
  logic             rst;
  logic             en;
  logic [OP_W-1:0]  op;
  bus_word_t        a;
  bus_word_t        b;
  logic [SEL_W-1:0] a_sel;
  logic [SEL_W-1:0] b_sel;
  logic             a_late;
  logic             b_late;
  bus_word_t        byp [NUM_BYP];
  bus_word_t        res;
  logic             res_valid;
  logic [RET_W-1:0] ret;
  logic             ret_en;

  // reference model state
  bus_word_t        byp_prev [NUM_BYP];
  expect_t          exp_q [$];
  logic             started = 1'b0;
  logic             cur_en = 1'b0;
  logic             cur_ok = 1'b0;
  logic [RET_W-1:0] cur_ret = '0;
  bus_word_t        cur_res;
  logic             have_res = 1'b0;
  int               seed;
  int               errors = 0;
  int               timeouts = 0;
  int               issued = 0;
  int               retired = 0;

  fpsu_top fpsu_top_i (
    .clk       (clk),
    .rst       (rst),
    .en        (en),
    .op        (op),
    .a         (a),
    .b         (b),
    .a_sel     (a_sel),
    .b_sel     (b_sel),
    .a_late    (a_late),
    .b_late    (b_late),
    .byp       (byp),
    .res       (res),
    .res_valid (res_valid),
    .ret       (ret),
    .ret_en    (ret_en)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic bus_word_t make_word(input data_t d, input logic bad);
    return '{par: (^d) ^ bad, data: d};
  endfunction

  function automatic bus_word_t source_word(input logic [SEL_W-1:0] s, input logic late,
      input bus_word_t direct);
    int idx;
    idx = int'(s) - 1;
    if (s == '0) begin
      return direct;
    end
    return late ? byp_prev[idx] : byp[idx];
  endfunction

  // lanes are added separately so a low carry cannot reach the high lane
  function automatic data_t expected_data(input logic [OP_W-1:0] o, input data_t x,
      input data_t y);
    case (o)
      OP_ADD:  return {x[63:32] + y[63:32], x[31:0] + y[31:0]};
      OP_SUB:  return {x[63:32] - y[63:32], x[31:0] - y[31:0]};
      OP_AND:  return x & y;
      OP_OR:   return x | y;
      OP_XOR:  return x ^ y;
      OP_ANDN: return x & ~y;
      default: return '0;
    endcase
  endfunction

  function automatic logic [RET_W-1:0] expected_code(input logic [OP_W-1:0] o,
      input bus_word_t wa, input bus_word_t wb);
    if ((^wa) || (^wb)) begin
      return RET_PARITY;
    end
    case (o)
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ANDN: return RET_OK;
      default: return RET_ILLEGAL;
    endcase
  endfunction

  task automatic report_failure(input string what, input logic [64:0] got,
      input logic [64:0] want);
    errors++;
    $display("FAILED at %0t: %s, got %h expected %h", $time, what, got, want);
  endtask

  always @(posedge clk) begin
    expect_t   e;
    bus_word_t wa;
    bus_word_t wb;
    byp_prev <= byp;
    started <= 1'b1;
    if (started && ret_en) begin
      retired <= retired + 1;
    end
    if (rst) begin
      exp_q.delete();
      cur_en <= 1'b0;
      cur_ok <= 1'b0;
      // ops still in flight are flushed and never retire
      issued <= retired + ((started && ret_en) ? 1 : 0);
    end else begin
      wa = source_word(a_sel, a_late, a);
      wb = source_word(b_sel, b_late, b);
      e.en = en;
      e.ret = expected_code(op, wa, wb);
      e.ok = en && (e.ret == RET_OK);
      e.data = expected_data(op, wa.data, wb.data);
      exp_q.push_back(e);
      if (en) begin
        issued <= issued + 1;
      end
      // head retires one edge after the entry behind it is pushed
      if (exp_q.size() > 1) begin
        e = exp_q.pop_front();
        cur_en <= e.en;
        cur_ok <= e.ok;
        cur_ret <= e.ret;
        if (e.ok) begin
          cur_res <= make_word(e.data, 1'b0);
          have_res <= 1'b1;
        end
      end
    end
  end

  retire_strobe: assert property (@(posedge clk) started |-> ret_en == cur_en)
    else report_failure("ret_en", 65'($sampled(ret_en)), 65'($sampled(cur_en)));

  retire_code: assert property (@(posedge clk) started && cur_en |-> ret == cur_ret)
    else report_failure("ret", 65'($sampled(ret)), 65'($sampled(cur_ret)));

  result_strobe: assert property (@(posedge clk) started |-> res_valid == cur_ok)
    else report_failure("res_valid", 65'($sampled(res_valid)), 65'($sampled(cur_ok)));

  result_word: assert property (@(posedge clk) have_res |-> res == cur_res)
    else report_failure("res", 65'($sampled(res)), 65'($sampled(cur_res)));

  result_parity: assert property (@(posedge clk) have_res |-> !(^res))
    else report_failure("res parity", 65'($sampled(^res)), 65'(0));

  quiet_in_reset: assert property (@(posedge clk) started && rst |=> !ret_en && !res_valid)
    else report_failure("strobe after reset edge", 65'($sampled({ret_en, res_valid})),
      65'(0));

  task automatic shuffle_bypass();
    for (int i = 0; i < NUM_BYP; i++) begin
      byp[i] = make_word({$random(seed), $random(seed)}, ($random(seed) & 31) == 0);
    end
  endtask

  task automatic drive_op(input logic [OP_W-1:0] o, input bus_word_t wa, input bus_word_t wb,
      input logic [SEL_W-1:0] sa, input logic [SEL_W-1:0] sb, input logic la, input logic lb);
    @(posedge clk);
    #2;
    en = 1'b1;
    op = o;
    a = wa;
    b = wb;
    a_sel = sa;
    b_sel = sb;
    a_late = la;
    b_late = lb;
    shuffle_bypass();
  endtask

  task automatic issue_direct(input logic [OP_W-1:0] o, input data_t da, input data_t db,
      input logic bad_a, input logic bad_b);
    drive_op(o, make_word(da, bad_a), make_word(db, bad_b), '0, '0, 1'b0, 1'b0);
  endtask

  task automatic idle();
    @(posedge clk);
    #2;
    en = 1'b0;
    shuffle_bypass();
  endtask

  task automatic issue_random();
    logic [OP_W-1:0] o;
    o = (($random(seed) & 3) != 0) ? {1'b0, 3'($random(seed))} : 4'($random(seed));
    drive_op(o,
      make_word({$random(seed), $random(seed)}, ($random(seed) & 15) == 0),
      make_word({$random(seed), $random(seed)}, ($random(seed) & 15) == 0),
      SEL_W'($unsigned($random(seed)) % 5), SEL_W'($unsigned($random(seed)) % 5),
      1'($random(seed)), 1'($random(seed)));
  endtask

  initial begin
    seed = 51;
    rst = 1'b1;
    en = 1'b0;
    op = OP_ADD;
    a = make_word('0, 1'b0);
    b = make_word('0, 1'b0);
    a_sel = '0;
    b_sel = '0;
    a_late = 1'b0;
    b_late = 1'b0;
    for (int i = 0; i < NUM_BYP; i++) begin
      byp[i] = make_word('0, 1'b0);
    end
    repeat (3) @(posedge clk);
    #2 rst = 1'b0;
    repeat (3) idle();

    // lane carries and borrows
    issue_direct(OP_ADD, {32'h0000_0001, 32'hffff_ffff}, {32'h0, 32'h0000_0001}, 1'b0, 1'b0);
    issue_direct(OP_ADD, {32'hffff_ffff, 32'h7fff_ffff}, {32'h1, 32'h1}, 1'b0, 1'b0);
    issue_direct(OP_SUB, {32'h5, 32'h0}, {32'h0, 32'h1}, 1'b0, 1'b0);
    issue_direct(OP_AND, 64'hf0f0_aaaa_1234_ffff, 64'h0ff0_5555_ffff_0f0f, 1'b0, 1'b0);
    issue_direct(OP_OR, 64'hf0f0_aaaa_1234_ffff, 64'h0ff0_5555_ffff_0f0f, 1'b0, 1'b0);
    issue_direct(OP_XOR, 64'hf0f0_aaaa_1234_ffff, 64'h0ff0_5555_ffff_0f0f, 1'b0, 1'b0);
    issue_direct(OP_ANDN, 64'hf0f0_aaaa_1234_ffff, 64'h0ff0_5555_ffff_0f0f, 1'b0, 1'b0);
    // error codes back to back, parity before illegal
    issue_direct(4'd3, 64'h1, 64'h2, 1'b0, 1'b0);
    issue_direct(4'hc, 64'h1, 64'h2, 1'b1, 1'b0);
    issue_direct(OP_XOR, 64'h1, 64'h2, 1'b0, 1'b1);
    // live and delayed bypass
    drive_op(OP_ADD, a, b, 3'd2, 3'd4, 1'b0, 1'b1);
    drive_op(OP_SUB, a, b, 3'd1, 3'd3, 1'b1, 1'b0);

    for (int n = 0; n < 300; n++) begin
      if (($random(seed) & 7) == 0) begin
        idle();
      end else begin
        issue_random();
      end
    end

    // reset hits clean ops in both stages
    issue_direct(OP_OR, 64'h0123_4567_89ab_cdef, 64'h1, 1'b0, 1'b0);
    issue_direct(OP_SUB, 64'h0, 64'h1, 1'b0, 1'b0);
    rst = 1'b1;
    repeat (3) issue_random();
    rst = 1'b0;
    idle();

    for (int t = 0; t < 8 && retired != issued; t++) begin
      @(posedge clk);
    end
    @(posedge clk);
    #1;
    if (retired != issued) begin
      timeouts++;
      $display("timeout: %0d operations issued but only %0d retired", issued, retired);
    end
    $display("errors: %0d check failures, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* fpsu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fpsu_top import fpsu_dims_pkg::*, fpsu_op_pkg::*; (
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire logic             en,
  input  wire logic [OP_W-1:0]  op,
  input  bus_word_t             a,
  input  bus_word_t             b,
  input  wire logic [SEL_W-1:0] a_sel,
  input  wire logic [SEL_W-1:0] b_sel,
  input  wire logic             a_late,
  input  wire logic             b_late,
  input  bus_word_t             byp [NUM_BYP],
  output bus_word_t             res,
  output logic                  res_valid,
  output logic [RET_W-1:0]      ret,
  output logic                  ret_en
);

  fpsu_issue_if iss ();

  issue_stage issue_stage_i (
    .clk    (clk),
    .rst    (rst),
    .en     (en),
    .op     (op),
    .a      (a),
    .b      (b),
    .a_sel  (a_sel),
    .b_sel  (b_sel),
    .a_late (a_late),
    .b_late (b_late),
    .byp    (byp),
    .iss    (iss.issue)
  );

  simd_exec simd_exec_i (
    .clk       (clk),
    .rst       (rst),
    .iss       (iss.exec),
    .res       (res),
    .res_valid (res_valid),
    .ret       (ret),
    .ret_en    (ret_en)
  );

endmodule

`default_nettype wire

/* simd_exec.sv */
`timescale 1ns/1ps
`default_nettype none

module simd_exec import fpsu_dims_pkg::*, fpsu_op_pkg::*; (
  input  wire logic         clk,
  input  wire logic         rst,
  fpsu_issue_if.exec        iss,
  output bus_word_t         res,
  output logic              res_valid,
  output logic [RET_W-1:0]  ret,
  output logic              ret_en
);

  data_t            lane_sum;
  data_t            lane_diff;
  data_t            rslt;
  logic [RET_W-1:0] ret_d;
  logic             ok;

  // lanes wrap on their own, no carry crosses a lane boundary
  always_comb begin
    for (int l = 0; l < NUM_LANES; l++) begin
      lane_sum[l*LANE_W +: LANE_W] =
        iss.opnd_a[l*LANE_W +: LANE_W] + iss.opnd_b[l*LANE_W +: LANE_W];
      lane_diff[l*LANE_W +: LANE_W] =
        iss.opnd_a[l*LANE_W +: LANE_W] - iss.opnd_b[l*LANE_W +: LANE_W];
    end
  end

  always_comb begin
    case (iss.kind)
      KIND_ADD:  rslt = lane_sum;
      KIND_SUB:  rslt = lane_diff;
      KIND_AND:  rslt = iss.opnd_a & iss.opnd_b;
      KIND_OR:   rslt = iss.opnd_a | iss.opnd_b;
      KIND_XOR:  rslt = iss.opnd_a ^ iss.opnd_b;
      KIND_ANDN: rslt = iss.opnd_a & ~iss.opnd_b;
      default:   rslt = '0;
    endcase
  end

  // parity first, then illegal
  always_comb begin
    if (iss.par_err) begin
      ret_d = RET_PARITY;
    end else if (iss.illegal) begin
      ret_d = RET_ILLEGAL;
    end else begin
      ret_d = RET_OK;
    end
  end

  assign ok = iss.valid && !iss.par_err && !iss.illegal;

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid <= 1'b0;
      ret_en <= 1'b0;
    end else begin
      res_valid <= ok;
      ret_en <= iss.valid;
      // res holds its last good value otherwise
      if (ok) begin
        res <= '{par: ^rslt, data: rslt};
      end
    end
    ret <= ret_d;
  end

  res_only_on_ok: assert property (
    @(posedge clk) disable iff (rst) res_valid |-> ret_en && ret == RET_OK
  ) else $error("res_valid without a clean retire, ret=%0d", ret);

endmodule

`default_nettype wire

/* issue_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_stage import fpsu_dims_pkg::*, fpsu_op_pkg::*; (
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire logic             en,
  input  wire logic [OP_W-1:0]  op,
  input  bus_word_t             a,
  input  bus_word_t             b,
  input  wire logic [SEL_W-1:0] a_sel,
  input  wire logic [SEL_W-1:0] b_sel,
  input  wire logic             a_late,
  input  wire logic             b_late,
  input  bus_word_t             byp [NUM_BYP],
  fpsu_issue_if.issue           iss
);

  op_kind_t kind_d;
  logic     a_par_err;
  logic     b_par_err;

  operand_forward fwd_a_i (
    .clk     (clk),
    .direct  (a),
    .sel     (a_sel),
    .late    (a_late),
    .byp     (byp),
    .opnd    (iss.opnd_a),
    .par_err (a_par_err)
  );

  operand_forward fwd_b_i (
    .clk     (clk),
    .direct  (b),
    .sel     (b_sel),
    .late    (b_late),
    .byp     (byp),
    .opnd    (iss.opnd_b),
    .par_err (b_par_err)
  );

  always_comb begin
    case (op)
      OP_ADD:  kind_d = KIND_ADD;
      OP_SUB:  kind_d = KIND_SUB;
      OP_AND:  kind_d = KIND_AND;
      OP_OR:   kind_d = KIND_OR;
      OP_XOR:  kind_d = KIND_XOR;
      OP_ANDN: kind_d = KIND_ANDN;
      default: kind_d = KIND_NONE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      iss.valid <= 1'b0;
    end else begin
      iss.valid <= en;
    end
    iss.kind <= kind_d;
    iss.illegal <= !(op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ANDN});
  end

  // either operand corrupt spoils the whole op
  assign iss.par_err = a_par_err | b_par_err;

  illegal_has_no_kind: assert property (
    @(posedge clk) disable iff (rst) iss.valid && iss.illegal |-> iss.kind == KIND_NONE
  ) else $error("illegal op issued with kind %s", iss.kind.name());

endmodule

`default_nettype wire

/* operand_forward.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_forward import fpsu_dims_pkg::*; (
  input  wire logic             clk,
  input  bus_word_t             direct,
  input  wire logic [SEL_W-1:0] sel,
  input  wire logic             late,
  input  bus_word_t             byp [NUM_BYP],
  output data_t                 opnd,
  output logic                  par_err
);

  // previous-cycle copy of every bypass bus
  bus_word_t byp_q [NUM_BYP];
  bus_word_t pick;

  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_BYP; i++) begin
      byp_q[i] <= byp[i];
    end
  end

  // sel 0 is the direct input, sel n is bus n-1
  always_comb begin
    pick = direct;
    for (int i = 0; i < NUM_BYP; i++) begin
      if (sel == SEL_W'(i + 1)) begin
        pick = late ? byp_q[i] : byp[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    opnd <= pick.data;
    // odd overall parity means a corrupted word
    par_err <= ^pick;
  end

  // selects beyond the last bus would silently fall back to direct
  sel_in_range: assert property (
    @(posedge clk) !$isunknown(sel) |-> sel <= SEL_W'(NUM_BYP)
  ) else $error("operand select %0d out of range", sel);

endmodule

`default_nettype wire

/* fpsu_issue_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface fpsu_issue_if import fpsu_dims_pkg::*, fpsu_op_pkg::*; ();

  // one decoded operation, meaningful while valid is high
  logic     valid;
  op_kind_t kind;
  data_t    opnd_a;
  data_t    opnd_b;
  logic     par_err;
  logic     illegal;

  modport issue (
    output valid,
    output kind,
    output opnd_a,
    output opnd_b,
    output par_err,
    output illegal
  );

  modport exec (
    input valid,
    input kind,
    input opnd_a,
    input opnd_b,
    input par_err,
    input illegal
  );

endinterface

`default_nettype wire

/* fpsu_op_pkg.sv */
`default_nettype none

package fpsu_op_pkg;

  localparam int OP_W = 4;

  // op field encodings, everything else is illegal
  localparam logic [OP_W-1:0] OP_ADD = 4'd0;
  localparam logic [OP_W-1:0] OP_SUB = 4'd1;
  localparam logic [OP_W-1:0] OP_AND = 4'd4;
  localparam logic [OP_W-1:0] OP_OR = 4'd5;
  localparam logic [OP_W-1:0] OP_XOR = 4'd6;
  // a and not b
  localparam logic [OP_W-1:0] OP_ANDN = 4'd7;

  typedef enum logic [2:0] {
    KIND_NONE,
    KIND_ADD,
    KIND_SUB,
    KIND_AND,
    KIND_OR,
    KIND_XOR,
    KIND_ANDN
  } op_kind_t;

  localparam int RET_W = 4;

  // retire status, parity wins over illegal
  localparam logic [RET_W-1:0] RET_OK = 4'd0;
  localparam logic [RET_W-1:0] RET_PARITY = 4'd1;
  localparam logic [RET_W-1:0] RET_ILLEGAL = 4'd2;

endpackage

`default_nettype wire

/* fpsu_dims_pkg.sv */
`default_nettype none

package fpsu_dims_pkg;

  // lane geometry
  localparam int LANE_W = 32;
  localparam int NUM_LANES = 2;
  localparam int DATA_W = LANE_W * NUM_LANES;

  // bypass network
  localparam int NUM_BYP = 4;
  // 0 selects the direct input, 1..NUM_BYP a bypass bus
  localparam int SEL_W = 3;

  typedef logic [DATA_W-1:0] data_t;

  // even overall parity, par is the xor of all data bits
  typedef struct packed {
    logic  par;
    data_t data;
  } bus_word_t;

endpackage

`default_nettype wire
